//--- rtl/dpMemPkg.sv
/* shared sizes, request structs and port state for the dual-port APB memory
   the array is fixed at 16 words of 16 bits, so nothing here is meant to be overridden */

package dpMemPkg;

  // address width, enough for the 16-word array
  localparam int addrBits = 4;

  // width of one stored word
  localparam int dataBits = 16;

  // number of words in the array
  localparam int memDepth = 16;

  // width of the saturating collision counter
  localparam int cntBits = 8;

  // one port's write request for the current cycle
  typedef struct packed {
    logic                valid;
    logic [addrBits-1:0] addr;
    logic [dataBits-1:0] data;
  } wrReq_t;

  // one port's read request for the current cycle
  typedef struct packed {
    logic                valid;
    logic [addrBits-1:0] addr;
  } rdReq_t;

  // registered read result returned to a port one cycle after its request
  typedef struct packed {
    logic [dataBits-1:0] data;
    logic                poisoned;
  } rdRsp_t;

  // APB port state
  // psIdle waits for a setup phase, psAccess is the first access cycle,
  // psReadWait is the single wait cycle of a read
  typedef enum logic [1:0] {
    psIdle,
    psAccess,
    psReadWait
  } portState_t;

endpackage

//--- rtl/apbMemPort.sv
/* APB slave for one memory port, writes complete with no wait state, reads with one
   the address seen in setup must match the access phase, otherwise the transfer errors */

`timescale 1ns/1ps

module apbMemPort (
  input  logic                             WEb,
  input  logic                             rstN,
  input  logic                             psel,
  input  logic                             penable,
  input  logic                             pwrite,
  input  logic [dpMemPkg::addrBits-1:0]    paddr,
  input  logic [dpMemPkg::dataBits-1:0]    pwdata,
  output logic [dpMemPkg::dataBits-1:0]    prdata,
  output logic                             pready,
  output logic                             pslverr,
  output dpMemPkg::wrReq_t                 wrReq,
  output dpMemPkg::rdReq_t                 rdReq,
  input  logic                             collide,
  input  dpMemPkg::rdRsp_t                 rdRsp
);

  dpMemPkg::portState_t               state;
  dpMemPkg::portState_t               stateNext;
  logic [dpMemPkg::addrBits-1:0]      setupAddr;
  logic                               rdBad;
  logic                               setupNow;
  logic                               accessNow;
  logic                               addrStable;
  logic                               inAccess;
  logic                               inReadWait;
  logic                               rdErr;

  // phase decode straight from the APB strobes
  assign setupNow   = psel && !penable;
  assign accessNow  = psel && penable;
  assign inAccess   = (state == dpMemPkg::psAccess) && accessNow;
  assign inReadWait = (state == dpMemPkg::psReadWait) && accessNow;

  // the address must not move between setup and access
  assign addrStable = (paddr == setupAddr);

  always_comb
  begin
    stateNext = state;
    case (state)
      dpMemPkg::psIdle:
      begin
        if (setupNow)
        begin
          stateNext = dpMemPkg::psAccess;
        end
      end
      dpMemPkg::psAccess:
      begin
        if (!psel)
        begin
          stateNext = dpMemPkg::psIdle;
        end
        else if (penable)
        begin
          // writes finish now, reads need the registered array output
          stateNext = pwrite ? dpMemPkg::psIdle : dpMemPkg::psReadWait;
        end
      end
      dpMemPkg::psReadWait:
      begin
        stateNext = dpMemPkg::psIdle;
      end
      default:
      begin
        stateNext = dpMemPkg::psIdle;
      end
    endcase
  end

  always_ff @(posedge WEb or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= dpMemPkg::psIdle;
      rdBad <= 1'b0;
    end
    else
    begin
      state <= stateNext;
      // remember an unstable read address for the wait cycle
      if (inAccess && !pwrite)
      begin
        rdBad <= !addrStable;
      end
    end
  end

  // a repeated setup while waiting for access restarts the stability check
  always_ff @(posedge WEb)
  begin
    if (setupNow && (state != dpMemPkg::psReadWait))
    begin
      setupAddr <= paddr;
    end
  end

  // requests into the core only for stable access cycles
  always_comb
  begin
    wrReq.valid = inAccess && pwrite && addrStable;
    wrReq.addr  = paddr;
    wrReq.data  = pwdata;
    rdReq.valid = inAccess && !pwrite && addrStable;
    rdReq.addr  = paddr;
  end

  assign rdErr = rdBad || rdRsp.poisoned;

  // poisoned or refused reads return zero
  assign prdata = (inReadWait && !rdErr) ? rdRsp.data : '0;

  assign pready = (inAccess && pwrite) || inReadWait;

  always_comb
  begin
    pslverr = 1'b0;
    if (inAccess && pwrite)
    begin
      pslverr = !addrStable || collide;
    end
    else if (inReadWait)
    begin
      pslverr = rdErr;
    end
  end

endmodule

//--- rtl/memCore.sv
/* 16x16 storage shared by two ports, with one poison bit per word
   same-address writes in one cycle store zero as poisoned and count as a collision */

`timescale 1ns/1ps

module memCore (
  input  logic                          WEb,
  input  logic                          rstN,
  input  dpMemPkg::wrReq_t              wrReqA,
  input  dpMemPkg::wrReq_t              wrReqB,
  input  dpMemPkg::rdReq_t              rdReqA,
  input  dpMemPkg::rdReq_t              rdReqB,
  output logic                          collideA,
  output logic                          collideB,
  output dpMemPkg::rdRsp_t              rdRspA,
  output dpMemPkg::rdRsp_t              rdRspB,
  output logic [dpMemPkg::cntBits-1:0]  collisionCount
);

  logic [dpMemPkg::dataBits-1:0] mem [dpMemPkg::memDepth];
  logic [dpMemPkg::memDepth-1:0] poison;
  logic                          collision;
  logic                          sameAddr;
  logic                          counterFull;

  // two valid writes to one word in the same cycle
  assign sameAddr  = (wrReqA.addr == wrReqB.addr);
  assign collision = wrReqA.valid && wrReqB.valid && sameAddr;

  // both writers are told about the clash in the same cycle
  assign collideA = collision;
  assign collideB = collision;

  assign counterFull = (collisionCount == {dpMemPkg::cntBits{1'b1}});

  // array and poison update
  always_ff @(posedge WEb or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < dpMemPkg::memDepth; i++)
      begin
        mem[i] <= '0;
      end
      poison <= '0;
    end
    else if (collision)
    begin
      // neither value wins, the word is marked bad until rewritten
      mem[wrReqA.addr]    <= '0;
      poison[wrReqA.addr] <= 1'b1;
    end
    else
    begin
      // addresses differ here, so the two writes never overlap
      if (wrReqA.valid)
      begin
        mem[wrReqA.addr]    <= wrReqA.data;
        poison[wrReqA.addr] <= 1'b0;
      end
      if (wrReqB.valid)
      begin
        mem[wrReqB.addr]    <= wrReqB.data;
        poison[wrReqB.addr] <= 1'b0;
      end
    end
  end

  // read capture for port A
  // nonblocking reads see the word as it was before this edge's write
  always_ff @(posedge WEb)
  begin
    if (rdReqA.valid)
    begin
      rdRspA.data     <= mem[rdReqA.addr];
      rdRspA.poisoned <= poison[rdReqA.addr];
    end
  end

  // read capture for port B
  always_ff @(posedge WEb)
  begin
    if (rdReqB.valid)
    begin
      rdRspB.data     <= mem[rdReqB.addr];
      rdRspB.poisoned <= poison[rdReqB.addr];
    end
  end

  // collision counter holds at its maximum
  always_ff @(posedge WEb or negedge rstN)
  begin
    if (!rstN)
    begin
      collisionCount <= '0;
    end
    else if (collision && !counterFull)
    begin
      collisionCount <= collisionCount + 1'b1;
    end
  end

endmodule

//--- rtl/dualPortMem.sv
/* top level, two independent APB ports sharing one memory core
   both ports run on the rising edge of WEb and share one asynchronous reset */

`timescale 1ns/1ps

module dualPortMem (
  input  logic                          WEb,
  input  logic                          rstN,
  // port A
  input  logic                          pselA,
  input  logic                          penableA,
  input  logic                          pwriteA,
  input  logic [dpMemPkg::addrBits-1:0] paddrA,
  input  logic [dpMemPkg::dataBits-1:0] pwdataA,
  output logic [dpMemPkg::dataBits-1:0] prdataA,
  output logic                          preadyA,
  output logic                          pslverrA,
  // port B
  input  logic                          pselB,
  input  logic                          penableB,
  input  logic                          pwriteB,
  input  logic [dpMemPkg::addrBits-1:0] paddrB,
  input  logic [dpMemPkg::dataBits-1:0] pwdataB,
  output logic [dpMemPkg::dataBits-1:0] prdataB,
  output logic                          preadyB,
  output logic                          pslverrB,
  output logic [dpMemPkg::cntBits-1:0]  collisionCount
);

  dpMemPkg::wrReq_t wrReqA;
  dpMemPkg::wrReq_t wrReqB;
  dpMemPkg::rdReq_t rdReqA;
  dpMemPkg::rdReq_t rdReqB;
  dpMemPkg::rdRsp_t rdRspA;
  dpMemPkg::rdRsp_t rdRspB;
  logic             collideA;
  logic             collideB;

  apbMemPort portA (
    .WEb     (WEb),
    .rstN    (rstN),
    .psel    (pselA),
    .penable (penableA),
    .pwrite  (pwriteA),
    .paddr   (paddrA),
    .pwdata  (pwdataA),
    .prdata  (prdataA),
    .pready  (preadyA),
    .pslverr (pslverrA),
    .wrReq   (wrReqA),
    .rdReq   (rdReqA),
    .collide (collideA),
    .rdRsp   (rdRspA)
  );

  apbMemPort portB (
    .WEb     (WEb),
    .rstN    (rstN),
    .psel    (pselB),
    .penable (penableB),
    .pwrite  (pwriteB),
    .paddr   (paddrB),
    .pwdata  (pwdataB),
    .prdata  (prdataB),
    .pready  (preadyB),
    .pslverr (pslverrB),
    .wrReq   (wrReqB),
    .rdReq   (rdReqB),
    .collide (collideB),
    .rdRsp   (rdRspB)
  );

  memCore core (
    .WEb            (WEb),
    .rstN           (rstN),
    .wrReqA         (wrReqA),
    .wrReqB         (wrReqB),
    .rdReqA         (rdReqA),
    .rdReqB         (rdReqB),
    .collideA       (collideA),
    .collideB       (collideB),
    .rdRspA         (rdRspA),
    .rdRspB         (rdRspB),
    .collisionCount (collisionCount)
  );

endmodule

//--- verif/dualPortMem_props.sv
/* protocol and collision assertions bound into dualPortMem, sampled on the rising WEb edge
   every check is disabled while rstN is low */

`timescale 1ns/1ps

module dualPortMemProps (
  input logic                          WEb,
  input logic                          rstN,
  input logic                          pselA,
  input logic                          penableA,
  input logic                          pwriteA,
  input logic [dpMemPkg::addrBits-1:0] paddrA,
  input logic                          preadyA,
  input logic                          pslverrA,
  input logic                          pselB,
  input logic                          penableB,
  input logic                          pwriteB,
  input logic [dpMemPkg::addrBits-1:0] paddrB,
  input logic                          preadyB,
  input logic                          pslverrB,
  input logic [dpMemPkg::cntBits-1:0]  collisionCount
);

  int                            propErrs = 0;
  logic                          setupA;
  logic                          setupB;
  logic [dpMemPkg::addrBits-1:0] setupAddrA;
  logic [dpMemPkg::addrBits-1:0] setupAddrB;
  logic                          stableWrA;
  logic                          stableWrB;
  logic                          clash;

  // the previous cycle's setup phase and address, seen from the bus side only
  always_ff @(posedge WEb or negedge rstN)
  begin
    if (!rstN)
    begin
      setupA     <= 1'b0;
      setupB     <= 1'b0;
      setupAddrA <= '0;
      setupAddrB <= '0;
    end
    else
    begin
      setupA     <= pselA && !penableA;
      setupB     <= pselB && !penableB;
      setupAddrA <= paddrA;
      setupAddrB <= paddrB;
    end
  end

  // first access cycle of a write whose address held since setup
  assign stableWrA = pselA && penableA && pwriteA && setupA && (paddrA == setupAddrA);
  assign stableWrB = pselB && penableB && pwriteB && setupB && (paddrB == setupAddrB);

  // same-address writes from both ports in one cycle
  assign clash = stableWrA && stableWrB && (paddrA == paddrB);

  task automatic noteFail(input string what);
    $error("%s", what);
    propErrs++;
  endtask

  // an error is only signalled together with pready
  errNeedsReady: assert property (@(posedge WEb) disable iff (!rstN)
    (!pslverrA || preadyA) && (!pslverrB || preadyB))
    else noteFail("pslverr high without pready");

  // pready only inside an access phase
  readyInAccess: assert property (@(posedge WEb) disable iff (!rstN)
    (!preadyA || (pselA && penableA)) && (!preadyB || (pselB && penableB)))
    else noteFail("pready high outside an access phase");

  // a read completes after exactly one wait cycle
  readWaitA: assert property (@(posedge WEb) disable iff (!rstN)
    (pselA && penableA && !pwriteA && !$past(penableA)) |=> preadyA)
    else noteFail("port A read did not complete after one wait cycle");

  readWaitB: assert property (@(posedge WEb) disable iff (!rstN)
    (pselB && penableB && !pwriteB && !$past(penableB)) |=> preadyB)
    else noteFail("port B read did not complete after one wait cycle");

  // both writers see the error in the collision cycle
  clashErr: assert property (@(posedge WEb) disable iff (!rstN)
    clash |-> (pslverrA && pslverrB))
    else noteFail("collision without pslverr on both ports");

  // the counter steps by one per collision and holds at its maximum
  clashCount: assert property (@(posedge WEb) disable iff (!rstN)
    clash |=> (collisionCount == $past(collisionCount) + dpMemPkg::cntBits'(1))
      || (($past(collisionCount) == '1) && (collisionCount == '1)))
    else noteFail("collisionCount did not count the collision");

endmodule

bind dualPortMem dualPortMemProps props (
  .WEb            (WEb),
  .rstN           (rstN),
  .pselA          (pselA),
  .penableA       (penableA),
  .pwriteA        (pwriteA),
  .paddrA         (paddrA),
  .preadyA        (preadyA),
  .pslverrA       (pslverrA),
  .pselB          (pselB),
  .penableB       (penableB),
  .pwriteB        (pwriteB),
  .paddrB         (paddrB),
  .preadyB        (preadyB),
  .pslverrB       (pslverrB),
  .collisionCount (collisionCount)
);

//--- verif/tbDualPortMem.sv
/* testbench for dualPortMem, directed cases then LFSR rounds on both APB ports
   both ports always start a transfer in the same cycle, a shadow model predicts each response */

`timescale 1ns/1ps

module tbDualPortMem;

  localparam logic [1:0] opIdle     = 2'd0;
  localparam logic [1:0] opWrite    = 2'd1;
  localparam logic [1:0] opRead     = 2'd2;
  localparam int         dirRounds  = 24;
  localparam int         randRounds = 200;
  localparam int         cycleLimit = 3 * (dirRounds + randRounds) * 3;

  logic                          WEb;
  logic                          rstN;
  logic                          pselA;
  logic                          penableA;
  logic                          pwriteA;
  logic [dpMemPkg::addrBits-1:0] paddrA;
  logic [dpMemPkg::dataBits-1:0] pwdataA;
  logic [dpMemPkg::dataBits-1:0] prdataA;
  logic                          preadyA;
  logic                          pslverrA;
  logic                          pselB;
  logic                          penableB;
  logic                          pwriteB;
  logic [dpMemPkg::addrBits-1:0] paddrB;
  logic [dpMemPkg::dataBits-1:0] pwdataB;
  logic [dpMemPkg::dataBits-1:0] prdataB;
  logic                          preadyB;
  logic                          pslverrB;
  logic [dpMemPkg::cntBits-1:0]  collisionCount;

  logic [15:0]                   shadowMem [16];
  logic [15:0]                   shadowPoison;
  logic [dpMemPkg::cntBits-1:0]  expCount;
  logic [15:0]                   lfsr;
  int                            modelErrs = 0;
  int                            cycleCount = 0;

  dualPortMem dut (.*);

  always #20 WEb = ~WEb;

  // run limit, counted in WEb cycles
  always @(posedge WEb)
  begin
    cycleCount++;
    if (cycleCount >= cycleLimit)
    begin
      $display("timeout, the tests did not finish within %0d cycles", cycleLimit);
      $display("Test FAILED");
      $finish;
    end
  end

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic takeBits(input int n, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsrStep(lfsr);
      val  = {val[14:0], lfsr[0]};
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    assert (act === exp)
    else
    begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      modelErrs++;
    end
  endtask

  task automatic checkWord(input string name, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp)
    else
    begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      modelErrs++;
    end
  endtask

  // one sample of a busy port, a write must answer in its first access cycle
  task automatic samplePort(input string tag, input logic [1:0] op, input int waitCount,
                            input logic ready, input logic err, input logic [15:0] data,
                            input logic expErr, input logic [15:0] expData, inout logic done);
    if (waitCount == 0)
      checkBit({"pready", tag}, op == opWrite, ready);
    if (ready)
    begin
      checkBit({"pslverr", tag}, expErr, err);
      if (op == opRead)
        checkWord({"prdata", tag}, expData, data);
      done = 1'b1;
    end
    else if (waitCount >= 3)
    begin
      $display("port %s gave no pready within 3 cycles", tag);
      modelErrs++;
      done = 1'b1;
    end
  endtask

  // setup on both ports in the same cycle, then access until each port has pready
  // bad moves paddr between setup and access
  task automatic runRound(input logic [1:0] opA, input logic [3:0] addrA,
                          input logic [15:0] dataA, input logic badA,
                          input logic [1:0] opB, input logic [3:0] addrB,
                          input logic [15:0] dataB, input logic badB);
    logic        wrA;
    logic        wrB;
    logic        clash;
    logic        expErrA;
    logic        expErrB;
    logic [15:0] expDataA;
    logic [15:0] expDataB;
    logic        doneA;
    logic        doneB;
    int          waitCount;
    @(negedge WEb);
    pselA    = (opA != opIdle);
    penableA = 1'b0;
    pwriteA  = (opA == opWrite);
    paddrA   = addrA;
    pwdataA  = dataA;
    pselB    = (opB != opIdle);
    penableB = 1'b0;
    pwriteB  = (opB == opWrite);
    paddrB   = addrB;
    pwdataB  = dataB;
    @(negedge WEb);
    penableA = pselA;
    penableB = pselB;
    if (badA)
      paddrA = addrA ^ 4'h1;
    if (badB)
      paddrB = addrB ^ 4'h1;
    // reads see the words as they were before this cycle's writes
    wrA      = (opA == opWrite) && !badA;
    wrB      = (opB == opWrite) && !badB;
    clash    = wrA && wrB && (addrA == addrB);
    expErrA  = badA || ((opA == opWrite) ? clash : shadowPoison[addrA]);
    expErrB  = badB || ((opB == opWrite) ? clash : shadowPoison[addrB]);
    expDataA = expErrA ? 16'h0000 : shadowMem[addrA];
    expDataB = expErrB ? 16'h0000 : shadowMem[addrB];
    if (clash)
    begin
      shadowMem[addrA]    = '0;
      shadowPoison[addrA] = 1'b1;
      if (expCount != '1)
        expCount = expCount + dpMemPkg::cntBits'(1);
    end
    else
    begin
      if (wrA)
      begin
        shadowMem[addrA]    = dataA;
        shadowPoison[addrA] = 1'b0;
      end
      if (wrB)
      begin
        shadowMem[addrB]    = dataB;
        shadowPoison[addrB] = 1'b0;
      end
    end
    doneA     = (opA == opIdle);
    doneB     = (opB == opIdle);
    waitCount = 0;
    while (!(doneA && doneB))
    begin
      #10;
      if (!doneA)
        samplePort("A", opA, waitCount, preadyA, pslverrA, prdataA, expErrA, expDataA, doneA);
      if (!doneB)
        samplePort("B", opB, waitCount, preadyB, pslverrB, prdataB, expErrB, expDataB, doneB);
      waitCount++;
      @(negedge WEb);
      if (doneA)
      begin
        pselA    = 1'b0;
        penableA = 1'b0;
      end
      if (doneB)
      begin
        pselB    = 1'b0;
        penableB = 1'b0;
      end
    end
    checkWord("collisionCount", {8'h00, expCount}, {8'h00, collisionCount});
  endtask

  // the address window of 4 words moves every 16 rounds so that both ports collide
  task automatic randomRound(input int idx);
    logic [15:0] r;
    logic [3:0]  base;
    logic [1:0]  op [2];
    logic [3:0]  addr [2];
    logic [15:0] data [2];
    logic        bad [2];
    base = 4'(((idx / 16) * 4) % 16);
    for (int p = 0; p < 2; p++)
    begin
      takeBits(2, r);
      op[p] = (r[1:0] == 2'd0) ? opIdle : (r[0] ? opWrite : opRead);
      takeBits(2, r);
      addr[p] = base + {2'b00, r[1:0]};
      takeBits(16, data[p]);
      takeBits(3, r);
      bad[p] = (r[2:0] == 3'd0);
    end
    runRound(op[0], addr[0], data[0], bad[0], op[1], addr[1], data[1], bad[1]);
  endtask

  initial
  begin
    WEb      = 1'b0;
    rstN     = 1'b0;
    pselA    = 1'b0;
    penableA = 1'b0;
    pwriteA  = 1'b0;
    paddrA   = '0;
    pwdataA  = '0;
    pselB    = 1'b0;
    penableB = 1'b0;
    pwriteB  = 1'b0;
    paddrB   = '0;
    pwdataB  = '0;
    lfsr     = 16'd75;
    expCount = '0;
    shadowPoison = '0;
    for (int i = 0; i < 16; i++)
      shadowMem[i] = '0;
    repeat (3) @(posedge WEb);
    @(negedge WEb);
    rstN = 1'b1;
    #10;
    checkBit("preadyA", 1'b0, preadyA);
    checkBit("pslverrA", 1'b0, pslverrA);
    checkBit("preadyB", 1'b0, preadyB);
    checkBit("pslverrB", 1'b0, pslverrB);
    checkWord("collisionCount", 16'h0000, {8'h00, collisionCount});
    // every word reads back as zero after reset
    for (int i = 0; i < 8; i++)
      runRound(opRead, 4'(i), 16'h0, 1'b0, opRead, 4'(15 - i), 16'h0, 1'b0);
    // write on one port, read on either
    runRound(opWrite, 4'd3, 16'hA5C3, 1'b0, opIdle, 4'd0, 16'h0, 1'b0);
    runRound(opIdle, 4'd0, 16'h0, 1'b0, opRead, 4'd3, 16'h0, 1'b0);
    runRound(opRead, 4'd3, 16'h0, 1'b0, opIdle, 4'd0, 16'h0, 1'b0);
    runRound(opIdle, 4'd0, 16'h0, 1'b0, opWrite, 4'd9, 16'h1234, 1'b0);
    runRound(opRead, 4'd9, 16'h0, 1'b0, opIdle, 4'd0, 16'h0, 1'b0);
    // collision poisons the word until a clean write
    runRound(opWrite, 4'd5, 16'h1111, 1'b0, opWrite, 4'd5, 16'h2222, 1'b0);
    runRound(opRead, 4'd5, 16'h0, 1'b0, opRead, 4'd5, 16'h0, 1'b0);
    runRound(opIdle, 4'd0, 16'h0, 1'b0, opWrite, 4'd5, 16'h3333, 1'b0);
    runRound(opRead, 4'd5, 16'h0, 1'b0, opIdle, 4'd0, 16'h0, 1'b0);
    // different addresses in one cycle, then read against a write to the same word
    runRound(opWrite, 4'd6, 16'h6666, 1'b0, opWrite, 4'd7, 16'h7777, 1'b0);
    runRound(opRead, 4'd6, 16'h0, 1'b0, opRead, 4'd7, 16'h0, 1'b0);
    runRound(opWrite, 4'd6, 16'h6A6A, 1'b0, opRead, 4'd6, 16'h0, 1'b0);
    runRound(opRead, 4'd6, 16'h0, 1'b0, opIdle, 4'd0, 16'h0, 1'b0);
    // address moves between setup and access
    runRound(opWrite, 4'd3, 16'hDEAD, 1'b1, opIdle, 4'd0, 16'h0, 1'b0);
    runRound(opRead, 4'd3, 16'h0, 1'b0, opRead, 4'd2, 16'h0, 1'b0);
    runRound(opRead, 4'd3, 16'h0, 1'b1, opIdle, 4'd0, 16'h0, 1'b0);
    for (int n = 0; n < randRounds; n++)
      randomRound(n);
    repeat (2) @(negedge WEb);
    $display("errors: model checks %0d, assertions %0d", modelErrs, dut.props.propErrs);
    if ((modelErrs == 0) && (dut.props.propErrs == 0))
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

//--- sim.f
rtl/dpMemPkg.sv
rtl/apbMemPort.sv
rtl/memCore.sv
rtl/dualPortMem.sv
verif/dualPortMem_props.sv
verif/tbDualPortMem.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and judge the run from its log
rm -rf obj_dir sim.log
verilator --binary --assert --top-module tbDualPortMem -f sim.f -o simDualPortMem \
  && ./obj_dir/simDualPortMem +verilator+error+limit+1000 2>&1 | tee sim.log
grep -qx "Test OK" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
